/* filelist.f */
verilog/rank_ctrl_pkg.sv
verilog/refresh_timer.sv
verilog/refresh_sequencer.sv
verilog/rank_fsm.sv
verilog/addr_mapper.sv
verilog/rank_ctrl_top.sv
dv/rank_ctrl_properties.sv
dv/rank_ctrl_tb.sv

/* Makefile */
# Verilator build and run for the rank controller testbench

VERILATOR ?= verilator
TOP       ?= rank_ctrl_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/rank_ctrl_tb.sv */
`default_nettype none

module rank_ctrl_tb
   import rank_ctrl_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   // longest full sequence times the stack depth, plus slack
   localparam int DRAIN_CYCLES = (REF_STACK_MAX + 1) * (T_RC + T_RP + T_RFC + T_ZQS + 2);
   localparam int PHASES       = 12;

   logic     clk;
   logic     rst_n;
   fe_req_t  fe_req_i;
   logic     fe_valid_i;
   logic     map_rbc_i;
   logic     bank_xor_i;
   logic     ref_disable_i;
   logic     zq_disable_i;
   logic     init_done_i;
   logic     fe_stall_o;
   logic     init_en_o;
   dec_req_t dec_o;
   logic     dec_valid_o;
   dram_cmd_t cmd_o;
   logic     cmd_valid_o;

   integer   seed;
   int       cyc;                     // falling edges since reset release
   int       rate;                    // request valid rate in percent
   logic     cfg_init_done, cfg_map_rbc, cfg_bank_xor, cfg_ref_dis, cfg_zq_dis;

   // reference model state
   logic     exp_valid;               // request accepted at the last edge
   dec_req_t exp_dec;
   logic     acc_since_ref;           // some request went out since the last REF
   logic     zq_due;
   int       pre_cyc, ref_cyc, seq_end;
   int       ref_total, refs_in_phase;
   int       dis_cycles;              // consecutive cycles with refresh disabled

   rank_ctrl_top dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .fe_req_i      (fe_req_i),
      .fe_valid_i    (fe_valid_i),
      .map_rbc_i     (map_rbc_i),
      .bank_xor_i    (bank_xor_i),
      .ref_disable_i (ref_disable_i),
      .zq_disable_i  (zq_disable_i),
      .init_done_i   (init_done_i),
      .fe_stall_o    (fe_stall_o),
      .init_en_o     (init_en_o),
      .dec_o         (dec_o),
      .dec_valid_o   (dec_valid_o),
      .cmd_o         (cmd_o),
      .cmd_valid_o   (cmd_valid_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;          // 40 ns period
   end

   task automatic stop_with_failure();
      $display("Errors found");
      $fatal(1, "simulation stopped on first failure");
   endtask

   task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
      if (got !== exp)
      begin
         $display("FAIL %0t ns: %s (got %0h, expected %0h)", $time, what, got, exp);
         stop_with_failure();
      end
   endtask

   // byte address split, written from the address layout rules
   function automatic dec_req_t decode(input fe_req_t r, input logic rbc, input logic bx);
      dec_req_t    d;
      logic [31:0] up;                  // everything above the column
      up      = r.addr >> (BYTE_OFS + COL_W);
      d.write = r.write;
      d.id    = r.id;
      d.col   = COL_W'(r.addr >> BYTE_OFS);
      if (rbc)
      begin
         d.bank = BANK_W'(up);
         d.row  = ROW_W'(up >> BANK_W);
      end
      else
      begin
         d.row  = ROW_W'(up);
         d.bank = BANK_W'(up >> ROW_W);
      end
      if (bx)
         d.bank = d.bank ^ BANK_W'(d.row);
      return d;
   endfunction

   // outputs of the cycle that just started, inputs still hold last drive
   task automatic observe();
      dram_cmd_e code;
      code = cmd_o.code;
      check_eq(cmd_valid_o, init_done_i, "cmd_valid_o one cycle after init_done_i");
      check_eq(init_en_o, !init_done_i, "init_en_o one cycle after init_done_i");
      if (!init_done_i)
         check_eq(fe_stall_o, 1'b1, "fe_stall_o low during init");
      check_eq(dec_valid_o, exp_valid, "dec_valid_o vs acceptance");
      if (exp_valid)
         check_eq(dec_o, exp_dec, "decoded request");
      dis_cycles = ref_disable_i ? dis_cycles + 1 : 0;
      if (dis_cycles > DRAIN_CYCLES)
         check_eq(code, CMD_NOP, "command on bus with refresh disabled and drained");
      if (code == CMD_PRE)
      begin
         check_eq(cmd_o.addr[A10_BIT], 1'b1, "PRE without A10 set");
         pre_cyc = cyc;
      end
      if (code == CMD_REF)
      begin
         check_eq(pre_cyc == cyc - T_RP, acc_since_ref, "PRE-all before REF vs accepted requests");
         acc_since_ref = 1'b0;
         ref_total     = ref_total + 1;
         refs_in_phase = refs_in_phase + 1;
         zq_due        = (ref_total % ZQ_EVERY == 0);   // every ZQ_EVERY-th REF
         ref_cyc       = cyc;
         seq_end       = cyc + T_RFC;
      end
      if (cyc == ref_cyc + T_RFC)
      begin
         if (zq_due && !zq_disable_i)
         begin
            check_eq(code, CMD_ZQCS, "ZQCS missing T_RFC after REF");
            seq_end = cyc + T_ZQS;      // done moves past the calibration
         end
         else
            check_eq(code, CMD_NOP, "ZQCS not expected after this REF");
      end
      else if (code == CMD_ZQCS)
         check_eq(code, CMD_NOP, "ZQCS outside its slot");
      if (cyc > ref_cyc && cyc <= seq_end)
         check_eq(fe_stall_o, 1'b1, "fe_stall_o low before the final wait ended");
   endtask

   // one clock: check, then drive on the falling edge and predict acceptance
   task automatic step();
      fe_req_t req;
      logic    take;
      @(negedge clk);
      cyc = cyc + 1;
      observe();
      req.write     = 1'($random(seed));
      req.id        = FE_ID_W'($random(seed));
      req.addr      = $random(seed);
      take          = ($unsigned($random(seed)) % 100) < rate;
      init_done_i   = cfg_init_done;
      map_rbc_i     = cfg_map_rbc;
      bank_xor_i    = cfg_bank_xor;
      ref_disable_i = cfg_ref_dis;
      zq_disable_i  = cfg_zq_dis;
      fe_req_i      = req;
      fe_valid_i    = take;
      exp_valid     = take && !fe_stall_o;    // stall is state only, stable here
      if (exp_valid)
      begin
         exp_dec       = decode(req, cfg_map_rbc, cfg_bank_xor);
         acc_since_ref = 1'b1;
      end
   endtask

   task automatic wait_init_exit(input int limit);
      int n;
      n = 0;
      while (init_en_o && n < limit)
      begin
         step();
         n = n + 1;
      end
      if (init_en_o)
      begin
         $display("timeout: rank did not leave init after init_done_i");
         stop_with_failure();
      end
   endtask

   task automatic wait_stall_low(input int limit);
      int n;
      n = 0;
      while (fe_stall_o && n < limit)
      begin
         step();
         n = n + 1;
      end
      if (fe_stall_o)
      begin
         $display("timeout: front end stayed stalled at the end of the run");
         stop_with_failure();
      end
   endtask

   initial
   begin
      int len;
      int diff;
      seed          = 63500;
      rst_n         = 1'b0;
      fe_req_i      = '0;
      fe_valid_i    = 1'b0;
      map_rbc_i     = 1'b0;
      bank_xor_i    = 1'b0;
      ref_disable_i = 1'b0;
      zq_disable_i  = 1'b0;
      init_done_i   = 1'b0;
      {cfg_init_done, cfg_map_rbc, cfg_bank_xor, cfg_ref_dis, cfg_zq_dis} = '0;
      rate          = 50;               // stalled anyway until init ends
      cyc           = 0;
      exp_valid     = 1'b0;
      exp_dec       = '0;
      acc_since_ref = 1'b0;
      zq_due        = 1'b0;
      pre_cyc       = -1000;
      ref_cyc       = -1000;
      seq_end       = -1000;
      ref_total     = 0;
      refs_in_phase = 0;
      dis_cycles    = 0;
      repeat (3) @(negedge clk);        // three rising edges in reset
      rst_n = 1'b1;

      // random init delay, PHY still owns the bus
      len = 2 + $unsigned($random(seed)) % 20;
      repeat (len) step();
      cfg_init_done = 1'b1;
      wait_init_exit(4);

      for (int ph = 0; ph < PHASES; ph++)
      begin
         cfg_map_rbc   = 1'($random(seed));
         cfg_bank_xor  = 1'($random(seed));
         cfg_zq_dis    = ($unsigned($random(seed)) % 4) == 0;
         cfg_ref_dis   = (ph % 4) == 3;  // every fourth phase without refresh
         rate          = $unsigned($random(seed)) % 101;
         len           = 2000 + $unsigned($random(seed)) % 600;  // more intervals than the stack
         refs_in_phase = 0;
         repeat (len) step();
         if (!cfg_ref_dis)
         begin
            diff = refs_in_phase - len / T_REFI;
            check_eq(diff <= REF_STACK_MAX + 1 && diff >= -(REF_STACK_MAX + 1), 1'b1,
                     "REF count off from elapsed time over T_REFI");
         end
      end

      rate = 0;
      wait_stall_low(200);
      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

/* dv/rank_ctrl_properties.sv */
`default_nettype none

module rank_ctrl_properties
   import rank_ctrl_pkg::*;
(
   input wire logic      clk,
   input wire logic      rst_n,
   input wire dram_cmd_t cmd_o,
   input wire logic      cmd_valid_o,
   input wire logic      fe_stall_o,
   input wire logic      fe_valid_i,
   input wire logic      dec_valid_o
);
   timeunit 1ns;
   timeprecision 100ps;

   // bus belongs to the PHY during init
   nop_while_invalid: assert property (@(posedge clk) disable iff (!rst_n)
      !cmd_valid_o |-> cmd_o.code == CMD_NOP)
      else $error("command issued while cmd_valid_o low");

   // a stalled request must not leak through
   no_dec_after_stall: assert property (@(posedge clk) disable iff (!rst_n)
      (fe_stall_o && fe_valid_i) |=> !dec_valid_o)
      else $error("decoded request after a stalled cycle");

   pre_then_ref: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_o.code == CMD_PRE |-> ##T_RP cmd_o.code == CMD_REF)
      else $error("REF not T_RP cycles after precharge-all");

endmodule

bind rank_ctrl_top rank_ctrl_properties u_props (
   .clk         (clk),
   .rst_n       (rst_n),
   .cmd_o       (cmd_o),
   .cmd_valid_o (cmd_valid_o),
   .fe_stall_o  (fe_stall_o),
   .fe_valid_i  (fe_valid_i),
   .dec_valid_o (dec_valid_o)
);

`default_nettype wire

/* verilog/rank_ctrl_top.sv */
`default_nettype none

module rank_ctrl_top
   import rank_ctrl_pkg::*;
(
   input  wire logic    clk,
   input  wire logic    rst_n,
   input  wire fe_req_t fe_req_i,
   input  wire logic    fe_valid_i,
   input  wire logic    map_rbc_i,
   input  wire logic    bank_xor_i,
   input  wire logic    ref_disable_i,
   input  wire logic    zq_disable_i,
   input  wire logic    init_done_i,
   output logic         fe_stall_o,
   output logic         init_en_o,
   output dec_req_t     dec_o,
   output logic         dec_valid_o,
   output dram_cmd_t    cmd_o,
   output logic         cmd_valid_o
);

   logic ref_pending;    // timer to FSM
   logic ref_issued;     // sequencer to timer
   logic seq_start;
   logic seq_pre_all;
   logic seq_done;
   logic accept_en;
   logic req_taken;
   logic init_en;

   refresh_timer u_refresh_timer (
      .clk           (clk),
      .rst_n         (rst_n),
      .init_done_i   (init_done_i),
      .ref_disable_i (ref_disable_i),
      .ref_issued_i  (ref_issued),
      .ref_pending_o (ref_pending)
   );

   refresh_sequencer u_refresh_sequencer (
      .clk          (clk),
      .rst_n        (rst_n),
      .start_i      (seq_start),
      .pre_all_i    (seq_pre_all),
      .zq_disable_i (zq_disable_i),
      .cmd_o        (cmd_o),
      .ref_issued_o (ref_issued),
      .done_o       (seq_done)
   );

   rank_fsm u_rank_fsm (
      .clk           (clk),
      .rst_n         (rst_n),
      .init_done_i   (init_done_i),
      .ref_pending_i (ref_pending),
      .seq_done_i    (seq_done),
      .req_taken_i   (req_taken),
      .init_en_o     (init_en),
      .fe_stall_o    (fe_stall_o),
      .accept_en_o   (accept_en),
      .seq_start_o   (seq_start),
      .seq_pre_all_o (seq_pre_all)
   );

   addr_mapper u_addr_mapper (
      .clk         (clk),
      .rst_n       (rst_n),
      .fe_req_i    (fe_req_i),
      .fe_valid_i  (fe_valid_i),
      .accept_en_i (accept_en),
      .map_rbc_i   (map_rbc_i),
      .bank_xor_i  (bank_xor_i),
      .req_taken_o (req_taken),
      .dec_o       (dec_o),
      .dec_valid_o (dec_valid_o)
   );

   assign init_en_o   = init_en;
   assign cmd_valid_o = !init_en;   // PHY owns the command bus during init

endmodule

`default_nettype wire

/* verilog/addr_mapper.sv */
`default_nettype none

module addr_mapper
   import rank_ctrl_pkg::*;
(
   input  wire logic    clk,
   input  wire logic    rst_n,
   input  wire fe_req_t fe_req_i,
   input  wire logic    fe_valid_i,
   input  wire logic    accept_en_i,
   input  wire logic    map_rbc_i,     // 1 row-bank-col, 0 bank-row-col
   input  wire logic    bank_xor_i,
   output logic         req_taken_o,
   output dec_req_t     dec_o,
   output logic         dec_valid_o
);

   localparam int COL_LSB = BYTE_OFS;
   localparam int UP_LSB  = BYTE_OFS + COL_W;   // first bit above the column

   logic [BANK_W-1:0] bank_raw;
   logic [BANK_W-1:0] bank;
   logic [ROW_W-1:0]  row;
   logic [COL_W-1:0]  col;

   assign col = fe_req_i.addr[COL_LSB +: COL_W];

   always_comb
   begin
      if (map_rbc_i)
      begin
         bank_raw = fe_req_i.addr[UP_LSB +: BANK_W];
         row      = fe_req_i.addr[UP_LSB + BANK_W +: ROW_W];
      end
      else
      begin
         row      = fe_req_i.addr[UP_LSB +: ROW_W];
         bank_raw = fe_req_i.addr[UP_LSB + ROW_W +: BANK_W];
      end
   end

   // spread same-bank strides over banks
   assign bank        = bank_xor_i ? bank_raw ^ row[BANK_W-1:0] : bank_raw;
   assign req_taken_o = fe_valid_i && accept_en_i;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         dec_valid_o <= 1'b0;
      else
         dec_valid_o <= req_taken_o;    // one cycle strobe per accepted request
   end

   always_ff @(posedge clk)
   begin
      if (req_taken_o)
      begin
         dec_o.write <= fe_req_i.write;
         dec_o.id    <= fe_req_i.id;
         dec_o.bank  <= bank;
         dec_o.row   <= row;
         dec_o.col   <= col;
      end
   end

endmodule

`default_nettype wire

/* verilog/rank_fsm.sv */
`default_nettype none

module rank_fsm
   import rank_ctrl_pkg::*;
(
   input  wire logic clk,
   input  wire logic rst_n,
   input  wire logic init_done_i,
   input  wire logic ref_pending_i,
   input  wire logic seq_done_i,
   input  wire logic req_taken_i,     // a request went to the bank machines
   output logic      init_en_o,
   output logic      fe_stall_o,
   output logic      accept_en_o,
   output logic      seq_start_o,
   output logic      seq_pre_all_o
);

   rank_state_e state_q, state_d;
   logic        touched_q;            // some bank may hold an open row
   logic        stall;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state_q <= RANK_INIT;
      else
         state_q <= state_d;
   end

   // no acceptance in the refresh entry cycle, so set and clear never meet
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         touched_q <= 1'b0;
      else if (seq_start_o)
         touched_q <= 1'b0;
      else if (req_taken_i)
         touched_q <= 1'b1;
   end

   always_comb
   begin
      state_d     = state_q;
      seq_start_o = 1'b0;
      case (state_q)
         RANK_INIT:
            if (init_done_i)
               state_d = RANK_ACTIVE;
         RANK_ACTIVE:
         begin
            if (ref_pending_i)
            begin
               seq_start_o = 1'b1;            // sequencer samples pre_all with this
               state_d     = RANK_REFRESH;
            end
         end
         RANK_REFRESH:
            if (seq_done_i)
               state_d = RANK_ACTIVE;
         default:
            state_d = RANK_INIT;
      endcase
   end

   assign stall         = !(state_q == RANK_ACTIVE && !ref_pending_i);
   assign fe_stall_o    = stall;
   assign accept_en_o   = !stall;
   assign init_en_o     = (state_q == RANK_INIT);   // PHY runs its own init
   assign seq_pre_all_o = touched_q;

endmodule

`default_nettype wire

/* verilog/refresh_sequencer.sv */
`default_nettype none

module refresh_sequencer
   import rank_ctrl_pkg::*;
(
   input  wire logic clk,
   input  wire logic rst_n,
   input  wire logic start_i,        // one cycle pulse from the rank FSM
   input  wire logic pre_all_i,      // banks may be open, close them first
   input  wire logic zq_disable_i,
   output dram_cmd_t cmd_o,
   output logic      ref_issued_o,   // pulse with the REF slot
   output logic      done_o          // last wait over
);

   typedef enum logic [2:0] {
      SEQ_IDLE     = 3'd0,
      SEQ_RC_WAIT  = 3'd1,   // let a running row cycle finish
      SEQ_RP_WAIT  = 3'd2,   // precharge to refresh
      SEQ_RFC_WAIT = 3'd3,   // refresh cycle time
      SEQ_ZQS_WAIT = 3'd4    // ZQ short calibration time
   } seq_state_e;

   seq_state_e           state_q, state_d;
   logic [SEQ_CNT_W-1:0] cnt_q, cnt_d;    // shared wait counter
   logic [ZQ_CNT_W-1:0]  zq_cnt_q;        // REFs since last ZQ, modulo ZQ_EVERY
   logic                 wait_done;

   assign wait_done = (cnt_q == '0);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= SEQ_IDLE;
         cnt_q   <= '0;
      end
      else
      begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
      end
   end

   // counts every REF, also those with ZQ disabled
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         zq_cnt_q <= '0;
      else if (ref_issued_o)
      begin
         if (zq_cnt_q == ZQ_CNT_W'(ZQ_EVERY - 1))
            zq_cnt_q <= '0;
         else
            zq_cnt_q <= zq_cnt_q + 1'b1;
      end
   end

   always_comb
   begin
      state_d      = state_q;
      cnt_d        = wait_done ? cnt_q : cnt_q - 1'b1;   // free running toward zero
      cmd_o.code   = CMD_NOP;
      cmd_o.addr   = '0;
      cmd_o.bank   = '0;
      ref_issued_o = 1'b0;
      done_o       = 1'b0;
      case (state_q)
         SEQ_IDLE:
         begin
            if (start_i)
            begin
               if (pre_all_i)
               begin
                  state_d = SEQ_RC_WAIT;
                  cnt_d   = SEQ_CNT_W'(T_RC - 1);    // PRE lands T_RC after start
               end
               else
               begin
                  state_d = SEQ_RP_WAIT;             // all closed, REF next cycle
                  cnt_d   = '0;
               end
            end
         end
         SEQ_RC_WAIT:
         begin
            if (wait_done)
            begin
               cmd_o.code          = CMD_PRE;
               cmd_o.addr[A10_BIT] = 1'b1;           // all banks
               state_d             = SEQ_RP_WAIT;
               cnt_d               = SEQ_CNT_W'(T_RP - 1);
            end
         end
         SEQ_RP_WAIT:
         begin
            if (wait_done)
            begin
               cmd_o.code   = CMD_REF;
               ref_issued_o = 1'b1;
               state_d      = SEQ_RFC_WAIT;
               cnt_d        = SEQ_CNT_W'(T_RFC - 1);
            end
         end
         SEQ_RFC_WAIT:
         begin
            if (wait_done)
            begin
               // counter wrapped to zero on the ZQ_EVERY-th REF
               if (zq_cnt_q == '0 && !zq_disable_i)
               begin
                  cmd_o.code = CMD_ZQCS;
                  state_d    = SEQ_ZQS_WAIT;
                  cnt_d      = SEQ_CNT_W'(T_ZQS - 1);
               end
               else
               begin
                  done_o  = 1'b1;
                  state_d = SEQ_IDLE;
               end
            end
         end
         SEQ_ZQS_WAIT:
         begin
            if (wait_done)
            begin
               done_o  = 1'b1;
               state_d = SEQ_IDLE;
            end
         end
         default:
            state_d = SEQ_IDLE;
      endcase
   end

endmodule

`default_nettype wire

/* verilog/refresh_timer.sv */
`default_nettype none

module refresh_timer
   import rank_ctrl_pkg::*;
(
   input  wire logic clk,
   input  wire logic rst_n,
   input  wire logic init_done_i,     // DRAM out of init, interval may run
   input  wire logic ref_disable_i,
   input  wire logic ref_issued_i,    // one REF went out this cycle
   output logic      ref_pending_o    // at least one refresh owed
);

   logic [REFI_W-1:0]  refi_cnt;      // interval down-counter
   logic [STACK_W-1:0] ref_stack;     // owed refreshes
   logic               incr_q;        // interval expired last cycle
   logic               run;

   assign run = init_done_i && !ref_disable_i;

   // count down while running, reload on zero or when stopped
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         refi_cnt <= REFI_W'(T_REFI);
         incr_q   <= 1'b0;
      end
      else if (run && refi_cnt != '0)
      begin
         refi_cnt <= refi_cnt - 1'b1;
         incr_q   <= 1'b0;
      end
      else
      begin
         refi_cnt <= REFI_W'(T_REFI);
         incr_q   <= run;              // only a real expiry owes a refresh
      end
   end

   // owed-refresh stack, issue and expiry in the same cycle cancel
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         ref_stack <= '0;
      else
         case ({incr_q, ref_issued_i})
            2'b10:
               if (ref_stack != STACK_W'(REF_STACK_MAX))
                  ref_stack <= ref_stack + 1'b1;   // saturate, extra ones are lost
            2'b01:
               if (ref_stack != '0)
                  ref_stack <= ref_stack - 1'b1;
            default:
               ref_stack <= ref_stack;
         endcase
   end

   assign ref_pending_o = (ref_stack != '0);

endmodule

`default_nettype wire

/* verilog/rank_ctrl_pkg.sv */
`default_nettype none

package rank_ctrl_pkg;

   // rank geometry
   localparam int BANKS       = 8;
   localparam int BANK_W      = $clog2(BANKS);   // 3
   localparam int ROW_W       = 16;
   localparam int COL_W       = 10;
   localparam int BYTE_OFS    = 3;               // 8 byte bus, below the column

   // front end
   localparam int FE_ADDR_W   = 32;
   localparam int FE_ID_W     = 8;

   // command bus toward the PHY
   localparam int DRAM_ADDR_W = 16;
   localparam int A10_BIT     = 10;              // auto precharge / precharge-all bit

   // refresh timing in controller clocks, 1:1 with the DRAM clock
   localparam int T_REFI        = 200;           // short interval for simulation
   localparam int REF_STACK_MAX = 7;
   localparam int T_RC          = 12;
   localparam int T_RP          = 4;
   localparam int T_RFC         = 20;
   localparam int T_ZQS         = 16;
   localparam int ZQ_EVERY      = 4;             // refreshes per ZQ short calibration

   // counter widths
   localparam int REFI_W    = $clog2(T_REFI + 1);
   localparam int STACK_W   = $clog2(REF_STACK_MAX + 1);
   localparam int ZQ_CNT_W  = $clog2(ZQ_EVERY);
   localparam int SEQ_CNT_W = $clog2(T_RC + T_RP + T_RFC + T_ZQS); // fits any single wait

   // DDR3 encodings of {cs_n, ras_n, cas_n, we_n} with a leading cke
   typedef enum logic [4:0] {
      CMD_NOP  = 5'b10111,
      CMD_PRE  = 5'b10010,
      CMD_REF  = 5'b10001,
      CMD_ZQCS = 5'b10110
   } dram_cmd_e;

   // one command slot, 24 bits
   typedef struct packed {
      dram_cmd_e              code;
      logic [DRAM_ADDR_W-1:0] addr;
      logic [BANK_W-1:0]      bank;
   } dram_cmd_t;

   // front-end request, 41 bits
   typedef struct packed {
      logic                 write;
      logic [FE_ID_W-1:0]   id;
      logic [FE_ADDR_W-1:0] addr;
   } fe_req_t;

   // decoded request toward the bank machines, 38 bits
   typedef struct packed {
      logic               write;
      logic [FE_ID_W-1:0] id;
      logic [BANK_W-1:0]  bank;
      logic [ROW_W-1:0]   row;
      logic [COL_W-1:0]   col;
   } dec_req_t;

   typedef enum logic [1:0] {
      RANK_INIT    = 2'd0,
      RANK_ACTIVE  = 2'd1,
      RANK_REFRESH = 2'd2
   } rank_state_e;

endpackage

`default_nettype wire
